// File: axi_avmm.f
+incdir+hw
hw/axi_avmm_pkg.sv
hw/axi_avmm_fifo2.sv
hw/axi_avmm_rd_meta.sv
hw/axi_avmm_bridge.sv
hw/avmm_burst_mem.sv
hw/axi_avmm_top.sv
bench/tb_axi_avmm.sv

// File: Bender.yml
package:
  name: axi_avmm

sources:
  - include_dirs:
      - hw
    files:
      - hw/axi_avmm_pkg.sv
      - hw/axi_avmm_fifo2.sv
      - hw/axi_avmm_rd_meta.sv
      - hw/axi_avmm_bridge.sv
      - hw/avmm_burst_mem.sv
      - hw/axi_avmm_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_axi_avmm.sv

// File: bench/tb_axi_avmm.sv
`timescale 1ns/10ps
`include "axi_avmm_defs.svh"

module tb_axi_avmm
    import axi_avmm_pkg::*;
();

    localparam int WORDS           = 2 ** `AXI_AVMM_WORD_ADDR_W;
    localparam int HANDSHAKE_LIMIT = 100;
    localparam int IDLE_LIMIT      = 400;

    typedef logic [`AXI_AVMM_WORD_ADDR_W-1:0] word_t;

    logic    clk;
    logic    reset_n;
    axi_aw_t aw;
    logic    awvalid;
    logic    awready;
    axi_w_t  w;
    logic    wvalid;
    logic    wready;
    axi_b_t  b;
    logic    bvalid;
    logic    bready;
    axi_ar_t ar;
    logic    arvalid;
    logic    arready;
    axi_r_t  r;
    logic    rvalid;
    logic    rready;

    // Reference memory image, expected responses in order and the beats of one write
    logic [`AXI_AVMM_DATA_W-1:0] model_mem [WORDS];
    axi_r_t                      exp_r_q [$];
    axi_b_t                      exp_b_q [$];
    axi_w_t                      wr_beats [16];
    logic                        mon_en;
    integer                      seed;

    axi_avmm_top u_dut
    (
        .clk,
        .reset_n,
        .aw,
        .awvalid,
        .awready,
        .w,
        .wvalid,
        .wready,
        .b,
        .bvalid,
        .bready,
        .ar,
        .arvalid,
        .arready,
        .r,
        .rvalid,
        .rready
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ============================================================
    // Failure reporting and result checks
    // ============================================================

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_b(input axi_b_t got, input axi_b_t exp);
        if (got.id !== exp.id)
            report_failure($sformatf("MISMATCH b.id got %h expected %h", got.id, exp.id));
        if (got.user !== exp.user)
            report_failure($sformatf("MISMATCH b.user got %h expected %h", got.user, exp.user));
        if (got.resp !== exp.resp)
            report_failure($sformatf("MISMATCH b.resp got %h expected %h", got.resp, exp.resp));
    endtask

    task automatic check_r(input axi_r_t got, input axi_r_t exp);
        if (got.data !== exp.data)
            report_failure($sformatf("MISMATCH r.data got %h expected %h", got.data, exp.data));
        if (got.id !== exp.id)
            report_failure($sformatf("MISMATCH r.id got %h expected %h", got.id, exp.id));
        if (got.user !== exp.user)
            report_failure($sformatf("MISMATCH r.user got %h expected %h", got.user, exp.user));
        if (got.resp !== exp.resp)
            report_failure($sformatf("MISMATCH r.resp got %h expected %h", got.resp, exp.resp));
        if (got.last !== exp.last)
            report_failure($sformatf("MISMATCH r.last got %h expected %h", got.last, exp.last));
    endtask

    // Responses are sampled mid-cycle, where every DUT output has settled
    always @(negedge clk)
    begin
        if (mon_en && rvalid)
        begin
            if (exp_r_q.size() == 0)
                report_failure("an R beat arrived while no read was outstanding");
            else
                check_r(r, exp_r_q.pop_front());
        end
        if (mon_en && bvalid)
        begin
            if (exp_b_q.size() == 0)
                report_failure("a B response arrived while no write was outstanding");
            else
                check_b(b, exp_b_q.pop_front());
        end
    end

    // ============================================================
    // AXI master channel drivers
    // ============================================================

    // Each driver starts 1 ns after an edge; ready seen at the negedge means the
    // transfer happens on the following edge
    task automatic send_ar(input axi_ar_t req);
        int   n;
        logic taken;
        ar      = req;
        arvalid = 1'b1;
        taken   = 1'b0;
        n       = 0;
        while (!taken)
        begin
            @(negedge clk);
            taken = arready;
            @(posedge clk);
            #1;
            n++;
            if (n > HANDSHAKE_LIMIT)
                report_failure("the AR channel never accepted the read request");
        end
        arvalid = 1'b0;
    endtask

    task automatic send_aw(input axi_aw_t req);
        int   n;
        logic taken;
        aw      = req;
        awvalid = 1'b1;
        taken   = 1'b0;
        n       = 0;
        while (!taken)
        begin
            @(negedge clk);
            taken = awready;
            @(posedge clk);
            #1;
            n++;
            if (n > HANDSHAKE_LIMIT)
                report_failure("the AW channel never accepted the write request");
        end
        awvalid = 1'b0;
    endtask

    // Beats come from wr_beats, and wvalid stays high between them
    task automatic send_w(input int count);
        int   n;
        logic taken;
        for (int k = 0; k < count; k++)
        begin
            w      = wr_beats[k];
            wvalid = 1'b1;
            taken  = 1'b0;
            n      = 0;
            while (!taken)
            begin
                @(negedge clk);
                taken = wready;
                @(posedge clk);
                #1;
                n++;
                if (n > HANDSHAKE_LIMIT)
                    report_failure("the W channel never accepted a data beat");
            end
        end
        wvalid = 1'b0;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(posedge clk);
        #1;
    endtask

    // Waits until the monitor has seen every expected response
    task automatic wait_idle();
        int n;
        n = 0;
        while (exp_r_q.size() != 0 || exp_b_q.size() != 0)
        begin
            @(posedge clk);
            #1;
            n++;
            if (n > IDLE_LIMIT)
                report_failure("responses were still outstanding when the wait ran out");
        end
    endtask

    // ============================================================
    // Burst level transactions
    // ============================================================

    // Order 0 sends AW and W together, 1 sends data first, 2 sends the address first.
    // A negative strb_sel gives random strobes on every beat
    task automatic write_burst(input word_t word, input logic [3:0] len,
                               input logic [3:0] id, input logic [1:0] user,
                               input int order, input int strb_sel);
        axi_aw_t req;
        axi_b_t  rsp;
        word_t   idx;
        req.id   = id;
        req.addr = {word, {`AXI_AVMM_BYTE_IDX_W{1'b0}}};
        req.len  = len;
        req.user = user;
        for (int k = 0; k <= len; k++)
        begin
            idx                = word + word_t'(k);
            wr_beats[k].data   = {$random(seed), $random(seed)};
            wr_beats[k].strb   = (strb_sel < 0) ? $random(seed) : strb_sel[7:0];
            wr_beats[k].last   = (k == len);
            // Model is updated byte by byte so lanes without a strobe keep their value
            for (int i = 0; i < `AXI_AVMM_STRB_W; i++)
                if (wr_beats[k].strb[i])
                    model_mem[idx][i*8 +: 8] = wr_beats[k].data[i*8 +: 8];
        end
        rsp.id   = id;
        rsp.user = user;
        rsp.resp = 2'b00;
        exp_b_q.push_back(rsp);
        case (order)
            0:
            begin
                fork
                    send_aw(req);
                    send_w(len + 1);
                join
            end
            1:
            begin
                send_w(len + 1);
                idle_cycles(4);
                send_aw(req);
            end
            default:
            begin
                send_aw(req);
                idle_cycles(4);
                send_w(len + 1);
            end
        endcase
    endtask

    // Expected beats are taken from the model when the request is issued
    task automatic read_burst(input word_t word, input logic [3:0] len,
                              input logic [3:0] id, input logic [1:0] user);
        axi_ar_t req;
        axi_r_t  beat;
        word_t   idx;
        req.id   = id;
        req.addr = {word, {`AXI_AVMM_BYTE_IDX_W{1'b0}}};
        req.len  = len;
        req.user = user;
        for (int k = 0; k <= len; k++)
        begin
            idx       = word + word_t'(k);
            beat.data = model_mem[idx];
            beat.id   = id;
            beat.user = user;
            beat.resp = 2'b00;
            beat.last = (k == len);
            exp_r_q.push_back(beat);
        end
        send_ar(req);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin
        int    n;
        word_t word;
        logic [3:0] len;
        seed    = 32'hc8c2f53a;
        mon_en  = 1'b0;
        reset_n = 1'b0;
        aw      = '0;
        awvalid = 1'b0;
        w       = '0;
        wvalid  = 1'b0;
        ar      = '0;
        arvalid = 1'b0;
        bready  = 1'b1;
        rready  = 1'b1;
        for (int i = 0; i < WORDS; i++)
            model_mem[i] = '0;

        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;
        mon_en  = 1'b1;

        // No response may appear after reset and the request channels must then open up
        for (int i = 0; i < 5; i++)
        begin
            @(negedge clk);
            if (rvalid !== 1'b0 || bvalid !== 1'b0)
                report_failure("a response valid was active before any request");
        end
        n = 0;
        while (!(awready === 1'b1 && arready === 1'b1))
        begin
            @(negedge clk);
            n++;
            if (n > HANDSHAKE_LIMIT)
                report_failure("awready and arready did not rise after reset");
        end
        @(posedge clk);
        #1;

        // Random write bursts are each read back over the same range with a new id and user
        for (int t = 0; t < 12; t++)
        begin
            word = $random(seed);
            len  = $random(seed);
            write_burst(word, len, $random(seed), $random(seed), 0, -1);
            wait_idle();
            read_burst(word, len, $random(seed), $random(seed));
            wait_idle();
        end

        // Full word first, then a partial strobe over it
        write_burst(8'h40, 4'd3, 4'h1, 2'h1, 0, 8'hff);
        wait_idle();
        write_burst(8'h40, 4'd3, 4'h2, 2'h2, 0, 8'h5a);
        wait_idle();
        read_burst(8'h40, 4'd3, 4'h3, 2'h3);
        wait_idle();

        // Read bursts issued back to back, answered in request order
        for (int t = 0; t < 6; t++)
            read_burst($random(seed), $random(seed), $random(seed), $random(seed));
        wait_idle();

        // Address after the data and then before it, with two beats fitting in the W FIFO
        write_burst(8'h80, 4'd1, 4'h5, 2'h1, 1, -1);
        wait_idle();
        write_burst(8'h90, 4'd1, 4'h6, 2'h2, 2, -1);
        wait_idle();
        read_burst(8'h80, 4'd1, 4'h7, 2'h0);
        read_burst(8'h90, 4'd1, 4'h8, 2'h3);
        wait_idle();

        // A few quiet cycles let the monitor catch any stray response
        idle_cycles(5);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: hw/axi_avmm_top.sv
`timescale 1ns/10ps

module axi_avmm_top
    import axi_avmm_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output axi_b_t  b,
    output logic    bvalid,
    input  logic    bready,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready
);

    // Avalon split bus between the bridge and the memory
    logic         rd_read;
    avmm_rd_cmd_t rd_cmd;
    logic         rd_waitrequest;
    logic         rd_readdatavalid;
    avmm_rd_rsp_t rd_rsp;
    logic         wr_write;
    avmm_wr_cmd_t wr_cmd;
    logic         wr_waitrequest;
    logic         wr_writeresponsevalid;
    avmm_wr_rsp_t wr_rsp;

    axi_avmm_bridge u_bridge
    (
        .clk,
        .reset_n,
        .aw,
        .awvalid,
        .awready,
        .w,
        .wvalid,
        .wready,
        .b,
        .bvalid,
        .bready,
        .ar,
        .arvalid,
        .arready,
        .r,
        .rvalid,
        .rready,
        .rd_read,
        .rd_cmd,
        .rd_waitrequest,
        .rd_readdatavalid,
        .rd_rsp,
        .wr_write,
        .wr_cmd,
        .wr_waitrequest,
        .wr_writeresponsevalid,
        .wr_rsp
    );

    avmm_burst_mem u_mem
    (
        .clk,
        .reset_n,
        .rd_read,
        .rd_cmd,
        .rd_waitrequest,
        .rd_readdatavalid,
        .rd_rsp,
        .wr_write,
        .wr_cmd,
        .wr_waitrequest,
        .wr_writeresponsevalid,
        .wr_rsp
    );

endmodule

// File: hw/avmm_burst_mem.sv
`timescale 1ns/10ps
`include "axi_avmm_defs.svh"

module avmm_burst_mem
    import axi_avmm_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  logic         rd_read,
    input  avmm_rd_cmd_t rd_cmd,
    output logic         rd_waitrequest,
    output logic         rd_readdatavalid,
    output avmm_rd_rsp_t rd_rsp,
    input  logic         wr_write,
    input  avmm_wr_cmd_t wr_cmd,
    output logic         wr_waitrequest,
    output logic         wr_writeresponsevalid,
    output avmm_wr_rsp_t wr_rsp
);

    localparam int WORDS  = 2 ** `AXI_AVMM_WORD_ADDR_W;
    localparam int NBYTES = `AXI_AVMM_STRB_W;

    typedef logic [`AXI_AVMM_WORD_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_AVMM_BCNT_W-1:0]      bcnt_t;

    logic [`AXI_AVMM_DATA_W-1:0] mem [WORDS];

    // ============================================================
    // Write side
    // ============================================================

    logic       wr_sop_q;
    addr_t      wr_addr_q;
    bcnt_t      wr_left_q;
    avmm_user_t wr_user_q;
    addr_t      wr_addr;
    bcnt_t      wr_left;
    avmm_user_t wr_user;
    logic       wr_accept;
    logic       wr_last;

    // Stall only in the cycle the response goes out
    assign wr_waitrequest = wr_writeresponsevalid;
    assign wr_accept      = wr_write && !wr_waitrequest;

    // First beat takes its burst fields from the command, later beats from the counters
    always_comb
    begin
        wr_addr = wr_sop_q ? wr_cmd.address : wr_addr_q;
        wr_left = wr_sop_q ? wr_cmd.burstcount : wr_left_q;
        wr_user = wr_sop_q ? wr_cmd.user : wr_user_q;
        wr_last = (wr_left == bcnt_t'(1));
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < WORDS; i++)
                mem[i] <= '0;
        end
        else if (wr_accept)
        begin
            // Only enabled byte lanes change
            for (int i = 0; i < NBYTES; i++)
                if (wr_cmd.byteenable[i])
                    mem[wr_addr][i*8 +: 8] <= wr_cmd.writedata[i*8 +: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_sop_q              <= 1'b1;
            wr_writeresponsevalid <= 1'b0;
        end
        else
        begin
            wr_writeresponsevalid <= wr_accept && wr_last;
            if (wr_accept)
                wr_sop_q <= wr_last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            wr_addr_q <= wr_addr + 1'b1;
            wr_left_q <= wr_left - 1'b1;
            wr_user_q <= wr_user;
        end
    end

    // Response echoes the burst user and always reports OKAY
    assign wr_rsp.user     = wr_user_q;
    assign wr_rsp.response = 2'b00;

    // ============================================================
    // Read side
    // ============================================================

    logic                        rd_busy_q;
    logic                        rd_delay_q;
    logic                        rd_valid_q;
    addr_t                       rd_addr_q;
    bcnt_t                       rd_left_q;
    logic [`AXI_AVMM_DATA_W-1:0] rd_data_q;

    // Only one burst is served at a time and the user field is ignored because the bridge keeps it
    assign rd_waitrequest   = rd_busy_q;
    assign rd_readdatavalid = rd_valid_q;
    assign rd_rsp.readdata  = rd_data_q;
    assign rd_rsp.response  = 2'b00;

    // Accept at edge t and wait one idle cycle, then send a beat from edge t+2 on every cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_busy_q  <= 1'b0;
            rd_delay_q <= 1'b0;
            rd_valid_q <= 1'b0;
        end
        else
        begin
            rd_valid_q <= 1'b0;
            if (!rd_busy_q)
            begin
                rd_busy_q  <= rd_read;
                rd_delay_q <= rd_read;
            end
            else if (rd_delay_q)
                rd_delay_q <= 1'b0;
            else if (rd_left_q != '0)
                rd_valid_q <= 1'b1;
            else
                rd_busy_q <= 1'b0;
        end
    end

    // Burst address and count are loaded on accept and stepped per beat
    always_ff @(posedge clk)
    begin
        if (!rd_busy_q)
        begin
            rd_addr_q <= rd_cmd.address;
            rd_left_q <= rd_cmd.burstcount;
        end
        else if (!rd_delay_q && rd_left_q != '0)
        begin
            rd_data_q <= mem[rd_addr_q];
            rd_addr_q <= rd_addr_q + 1'b1;
            rd_left_q <= rd_left_q - 1'b1;
        end
    end

endmodule

// File: hw/axi_avmm_bridge.sv
`timescale 1ns/10ps
`include "axi_avmm_defs.svh"

module axi_avmm_bridge
    import axi_avmm_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,

    // AXI slave side
    input  axi_aw_t      aw,
    input  logic         awvalid,
    output logic         awready,
    input  axi_w_t       w,
    input  logic         wvalid,
    output logic         wready,
    output axi_b_t       b,
    output logic         bvalid,
    input  logic         bready,
    input  axi_ar_t      ar,
    input  logic         arvalid,
    output logic         arready,
    output axi_r_t       r,
    output logic         rvalid,
    input  logic         rready,

    // Avalon split-bus master side
    output logic         rd_read,
    output avmm_rd_cmd_t rd_cmd,
    input  logic         rd_waitrequest,
    input  logic         rd_readdatavalid,
    input  avmm_rd_rsp_t rd_rsp,
    output logic         wr_write,
    output avmm_wr_cmd_t wr_cmd,
    input  logic         wr_waitrequest,
    input  logic         wr_writeresponsevalid,
    input  avmm_wr_rsp_t wr_rsp
);

    localparam int BCNT_W = `AXI_AVMM_BCNT_W;
    localparam int LO     = `AXI_AVMM_BYTE_IDX_W;
    localparam int HI     = `AXI_AVMM_ADDR_W - 1;

    // ============================================================
    // Reads
    // ============================================================

    logic                        meta_not_full;
    logic [`AXI_AVMM_ID_W-1:0]   meta_id;
    logic [`AXI_AVMM_USER_W-1:0] meta_user;
    logic                        meta_last;
    logic                        rd_error;

    always_comb
    begin
        // A read is only offered while there is room to remember its metadata
        arready           = !rd_waitrequest && meta_not_full;
        rd_read           = arvalid && meta_not_full;
        rd_cmd.address    = ar.addr[HI:LO];
        rd_cmd.burstcount = BCNT_W'(ar.len) + 1'b1;
        rd_cmd.user       = avmm_user_t'{user: ar.user, id: ar.id};

        // Data and status come from the memory, the rest is rebuilt locally
        rvalid            = rd_readdatavalid && !rd_error;
        r.data            = rd_rsp.readdata;
        r.resp            = rd_rsp.response;
        r.id              = meta_id;
        r.user            = meta_user;
        r.last            = meta_last;
    end

    axi_avmm_rd_meta u_rd_meta
    (
        .clk,
        .reset_n,
        .not_full(meta_not_full),
        .req_valid(arvalid && arready),
        .req(ar),
        .rsp_beat(rd_readdatavalid),
        .rsp_id(meta_id),
        .rsp_user(meta_user),
        .rsp_last(meta_last)
    );

    // Once a beat is dropped the read stream is out of step, so all later ones are hidden
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rd_error <= 1'b0;
        else if (rvalid && !rready)
            rd_error <= 1'b1;
    end

    // ============================================================
    // Writes
    // ============================================================

    axi_aw_t    aw_q;
    axi_w_t     w_q;
    logic       aw_q_valid;
    logic       w_q_valid;
    logic       wr_sop;
    logic       fwd_wr;
    avmm_user_t wr_user_q;
    logic       wr_error;

    // Address and data streams are joined here, the address is only needed on a first beat
    assign wr_write = w_q_valid && (aw_q_valid || !wr_sop);
    assign fwd_wr   = wr_write && !wr_waitrequest;

    axi_avmm_fifo2 #(.DATA_W($bits(axi_aw_t))) aw_fifo
    (
        .clk,
        .reset_n,
        .enq_data(aw),
        .enq_en(awvalid && awready),
        .not_full(awready),
        .first(aw_q),
        .deq_en(fwd_wr && wr_sop),
        .not_empty(aw_q_valid)
    );

    axi_avmm_fifo2 #(.DATA_W($bits(axi_w_t))) w_fifo
    (
        .clk,
        .reset_n,
        .enq_data(w),
        .enq_en(wvalid && wready),
        .not_full(wready),
        .first(w_q),
        .deq_en(fwd_wr),
        .not_empty(w_q_valid)
    );

    always_comb
    begin
        wr_cmd.address    = aw_q.addr[HI:LO];
        wr_cmd.burstcount = BCNT_W'(aw_q.len) + 1'b1;
        wr_cmd.writedata  = w_q.data;
        wr_cmd.byteenable = w_q.strb;
        // Later beats reuse the user held from the first beat, since aw_q has moved on
        wr_cmd.user       = wr_sop ? avmm_user_t'{user: aw_q.user, id: aw_q.id} : wr_user_q;

        bvalid            = wr_writeresponsevalid && !wr_error;
        b.id              = wr_rsp.user.id;
        b.user            = wr_rsp.user.user;
        b.resp            = wr_rsp.response;
    end

    // The beat after a last beat starts a new burst
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_sop   <= 1'b1;
            wr_error <= 1'b0;
        end
        else
        begin
            if (fwd_wr)
                wr_sop <= w_q.last;
            if (bvalid && !bready)
                wr_error <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fwd_wr && wr_sop)
            wr_user_q <= avmm_user_t'{user: aw_q.user, id: aw_q.id};
    end

    // ============================================================
    // Checks on the master
    // ============================================================

    // The byte offset is dropped, so any set bit there would silently move the access
    assert property (@(posedge clk) disable iff (!reset_n)
        !(arvalid && ar.addr[LO-1:0] != '0) && !(awvalid && aw.addr[LO-1:0] != '0))
        else $error("AXI address not aligned to the bus word");

    // No response buffering here, so the master has to take every R and B beat
    assert property (@(posedge clk) disable iff (!reset_n)
        !(rvalid && !rready) && !(bvalid && !bready))
        else $error("AXI response lost, rready or bready was low");

endmodule

// File: hw/axi_avmm_rd_meta.sv
`timescale 1ns/10ps
`include "axi_avmm_defs.svh"

module axi_avmm_rd_meta
    import axi_avmm_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_n,
    output logic                        not_full,
    input  logic                        req_valid,
    input  axi_ar_t                     req,
    input  logic                        rsp_beat,
    output logic [`AXI_AVMM_ID_W-1:0]   rsp_id,
    output logic [`AXI_AVMM_USER_W-1:0] rsp_user,
    output logic                        rsp_last
);

    localparam int DEPTH = `AXI_AVMM_META_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // What a read response needs that the memory does not return
    typedef struct packed {
        logic [`AXI_AVMM_ID_W-1:0]   id;
        logic [`AXI_AVMM_USER_W-1:0] user;
        logic [`AXI_AVMM_LEN_W-1:0]  len;
    } meta_t;

    meta_t                      meta_mem [DEPTH];
    meta_t                      head;
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [CNT_W-1:0]           cnt_q;
    logic [CNT_W-1:0]           cnt_next;
    logic [`AXI_AVMM_LEN_W-1:0] beat_q;
    logic                       pop;

    // Avalon returns bursts in order, so the oldest entry always owns the current beat
    assign head     = meta_mem[rd_ptr_q];
    assign rsp_id   = head.id;
    assign rsp_user = head.user;

    // The beat counter runs 0..len, so the last beat is where it meets len
    assign rsp_last = (beat_q == head.len);
    assign pop      = rsp_beat && rsp_last;

    assign cnt_next = cnt_q + CNT_W'(req_valid) - CNT_W'(pop);

    // Entry storage, written when the read command is accepted
    always_ff @(posedge clk)
    begin
        if (req_valid)
            meta_mem[wr_ptr_q] <= '{id: req.id, user: req.user, len: req.len};
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            beat_q   <= '0;
            not_full <= 1'b0;
        end
        else
        begin
            cnt_q    <= cnt_next;
            not_full <= (cnt_next != CNT_W'(DEPTH));
            if (req_valid)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (rsp_beat)
                beat_q <= rsp_last ? '0 : beat_q + 1'b1;
        end
    end

    // A beat with nothing recorded means the memory sent more beats than requested
    assert property (@(posedge clk) disable iff (!reset_n) rsp_beat |-> (cnt_q != '0))
        else $error("read beat arrived with no request in the metadata buffer");

endmodule

// File: hw/axi_avmm_fifo2.sv
`timescale 1ns/10ps

module axi_avmm_fifo2
#(
    parameter int DATA_W = 8
)
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic [DATA_W-1:0] enq_data,
    input  logic              enq_en,
    output logic              not_full,
    output logic [DATA_W-1:0] first,
    input  logic              deq_en,
    output logic              not_empty
);

    // Head entry is the output register itself, the second entry sits behind it
    logic [DATA_W-1:0] second_q;
    logic [1:0]        cnt_q;
    logic [1:0]        cnt_next;

    assign cnt_next = cnt_q + {1'b0, enq_en} - {1'b0, deq_en};

    // Payload path
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            // With one entry left and a new one arriving, the new one becomes the head
            if (enq_en && cnt_q == 2'd1)
                first <= enq_data;
            else
                first <= second_q;
        end
        else if (enq_en && cnt_q == 2'd0)
        begin
            first <= enq_data;
        end

        // Second slot takes every arrival and only matters when the head is busy
        if (enq_en)
            second_q <= enq_data;
    end

    // Status flags are registered, so ready toward the master is never combinational
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cnt_q     <= 2'd0;
            not_full  <= 1'b0;
            not_empty <= 1'b0;
        end
        else
        begin
            cnt_q     <= cnt_next;
            not_full  <= (cnt_next != 2'd2);
            not_empty <= (cnt_next != 2'd0);
        end
    end

    // Producer and consumer must both honour the flags
    assert property (@(posedge clk) disable iff (!reset_n)
        !(enq_en && !not_full) && !(deq_en && !not_empty))
        else $error("fifo2 overflow or underflow");

endmodule

// File: hw/axi_avmm_pkg.sv
`include "axi_avmm_defs.svh"

package axi_avmm_pkg;

    // ============================================================
    // AXI channel payloads
    // ============================================================

    // Write address channel
    typedef struct packed {
        logic [`AXI_AVMM_ID_W-1:0]   id;
        logic [`AXI_AVMM_ADDR_W-1:0] addr;
        logic [`AXI_AVMM_LEN_W-1:0]  len;
        logic [`AXI_AVMM_USER_W-1:0] user;
    } axi_aw_t;

    // Read address channel, same fields as the write address
    typedef struct packed {
        logic [`AXI_AVMM_ID_W-1:0]   id;
        logic [`AXI_AVMM_ADDR_W-1:0] addr;
        logic [`AXI_AVMM_LEN_W-1:0]  len;
        logic [`AXI_AVMM_USER_W-1:0] user;
    } axi_ar_t;

    // Write data beat
    typedef struct packed {
        logic [`AXI_AVMM_DATA_W-1:0] data;
        logic [`AXI_AVMM_STRB_W-1:0] strb;
        logic                        last;
    } axi_w_t;

    // Write response
    typedef struct packed {
        logic [`AXI_AVMM_ID_W-1:0]   id;
        logic [`AXI_AVMM_USER_W-1:0] user;
        logic [1:0]                  resp;
    } axi_b_t;

    // Read data beat
    typedef struct packed {
        logic [`AXI_AVMM_DATA_W-1:0] data;
        logic [`AXI_AVMM_ID_W-1:0]   id;
        logic [`AXI_AVMM_USER_W-1:0] user;
        logic [1:0]                  resp;
        logic                        last;
    } axi_r_t;

    // ============================================================
    // Avalon split read/write bus
    // ============================================================

    // Avalon user field carries AXI user above AXI id
    typedef struct packed {
        logic [`AXI_AVMM_USER_W-1:0] user;
        logic [`AXI_AVMM_ID_W-1:0]   id;
    } avmm_user_t;

    // Write beat, address and burstcount count only on the first beat
    typedef struct packed {
        logic [`AXI_AVMM_WORD_ADDR_W-1:0] address;
        logic [`AXI_AVMM_BCNT_W-1:0]      burstcount;
        logic [`AXI_AVMM_DATA_W-1:0]      writedata;
        logic [`AXI_AVMM_STRB_W-1:0]      byteenable;
        avmm_user_t                       user;
    } avmm_wr_cmd_t;

    // Read burst command, one per burst
    typedef struct packed {
        logic [`AXI_AVMM_WORD_ADDR_W-1:0] address;
        logic [`AXI_AVMM_BCNT_W-1:0]      burstcount;
        avmm_user_t                       user;
    } avmm_rd_cmd_t;

    // Read data beat from the slave
    typedef struct packed {
        logic [`AXI_AVMM_DATA_W-1:0] readdata;
        logic [1:0]                  response;
    } avmm_rd_rsp_t;

    // Write response, one per burst
    typedef struct packed {
        avmm_user_t user;
        logic [1:0] response;
    } avmm_wr_rsp_t;

endpackage

// File: hw/axi_avmm_defs.svh
`ifndef AXI_AVMM_DEFS_SVH
`define AXI_AVMM_DEFS_SVH

// ============================================================
// Bus geometry shared by the bridge, the memory and the bench
// ============================================================

// AXI byte address, covering the whole memory
`define AXI_AVMM_ADDR_W 11

// Data bus width in bits and its byte-enable width
`define AXI_AVMM_DATA_W 64
`define AXI_AVMM_STRB_W 8

// AXI transaction ID and USER sideband widths
`define AXI_AVMM_ID_W 4
`define AXI_AVMM_USER_W 2

// AXI length field, so bursts of 1 to 16 beats
`define AXI_AVMM_LEN_W 4

// Avalon burstcount holds len + 1, which needs one more bit than len
`define AXI_AVMM_BCNT_W 5

// Byte offset bits inside one bus word, dropped on the Avalon side
`define AXI_AVMM_BYTE_IDX_W 3

// Avalon word address, which is the AXI address without the byte offset
`define AXI_AVMM_WORD_ADDR_W 8

// Read requests that may be outstanding at once
`define AXI_AVMM_META_DEPTH 8

`endif
